//--- include/lpif_defs.svh
//////////////////////////////
// Widths and link word field offsets
// Field offsets must track the widths below
//////////////////////////////

`ifndef LPIF_DEFS_SVH
`define LPIF_DEFS_SVH

// Stream field widths
`define LPIF_DATA_W       256
`define LPIF_CRC_W        16
`define LPIF_STATE_W      4
`define LPIF_PROTID_W     2

// Link word and channel words
`define LPIF_LINK_W       281
`define LPIF_PHY_W        160
`define LPIF_PHY0_SLICE   141
`define LPIF_PHY1_SLICE   140
`define LPIF_STB_BIT      158
`define LPIF_MRK_BIT      159

// Online and strobe counters
`define LPIF_CNT_W        16

// Link word field offsets, bit 0 upward
`define LPIF_VALID_LSB    0
`define LPIF_CRCV_LSB     1
`define LPIF_CRC_LSB      2
`define LPIF_DVALID_LSB   18
`define LPIF_DATA_LSB     19
`define LPIF_PROTID_LSB   275
`define LPIF_STATE_LSB    277

`endif

//--- rtl/lpif_stream_pkg.sv
//////////////////////////////
// User stream types
//////////////////////////////

`include "lpif_defs.svh"

package lpif_stream_pkg;

  // LPIF state as seen on the stream
  typedef logic [`LPIF_STATE_W-1:0] stream_state_t;

  // Protocol id
  typedef logic [`LPIF_PROTID_W-1:0] protid_t;

  // Packed stream word
  // valid sits at bit 0 and state at the top
  typedef logic [`LPIF_LINK_W-1:0] link_word_t;

endpackage

//--- rtl/lpif_phy_pkg.sv
//////////////////////////////
// PHY channel types
//////////////////////////////

`include "lpif_defs.svh"

package lpif_phy_pkg;

  // One die-to-die channel word
  typedef logic [`LPIF_PHY_W-1:0] phy_word_t;

  // Marker bits, bit 0 for channel 0
  typedef logic [1:0] marker_t;

endpackage

//--- rtl/ll_auto_sync.sv
//////////////////////////////
// Hold counts saturate once their delay is reached
// A strobe period of zero gives no strobe
//////////////////////////////

`include "lpif_defs.svh"

module ll_auto_sync (
  input  logic                   clk_wr,
  input  logic                   reset,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [`LPIF_CNT_W-1:0] delay_x_value,
  input  logic [`LPIF_CNT_W-1:0] delay_y_value,
  input  logic [`LPIF_CNT_W-1:0] delay_z_value,
  input  lpif_phy_pkg::marker_t  tx_mrk_userbit,
  input  logic                   tx_stb_userbit,
  output logic                   tx_online_delay,
  output logic                   rx_online_delay,
  output lpif_phy_pkg::marker_t  tx_auto_mrk_userbit,
  output logic                   tx_auto_stb_userbit
);

  // Lane 0 is TX, lane 1 is RX
  logic [1:0]             online_in;
  logic [1:0]             online_dly;
  logic [`LPIF_CNT_W-1:0] hold_lim [2];
  logic [`LPIF_CNT_W-1:0] hold_cnt [2];
  logic [`LPIF_CNT_W-1:0] stb_cnt;
  logic [`LPIF_CNT_W-1:0] stb_cnt_inc;

  assign online_in   = {rx_online, tx_online};
  assign hold_lim[0] = delay_y_value;
  assign hold_lim[1] = delay_x_value;

  //////////////////////////////
  // Online hold counters

  // Count consecutive online cycles, drop at once on loss
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      if (reset || !online_in[i]) begin
        hold_cnt[i]   <= '0;
        online_dly[i] <= 1'b0;
      end else if (hold_cnt[i] >= hold_lim[i]) begin
        online_dly[i] <= 1'b1;
      end else begin
        hold_cnt[i] <= hold_cnt[i] + 1'b1;
      end
    end
  end

  assign tx_online_delay = online_dly[0];
  assign rx_online_delay = online_dly[1];

  //////////////////////////////
  // Strobe and marker

  assign stb_cnt_inc = stb_cnt + 1'b1;

  // Free running period count while TX is online
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      stb_cnt             <= '0;
      tx_auto_stb_userbit <= 1'b0;
    end else if (delay_z_value == '0) begin
      stb_cnt             <= '0;
      tx_auto_stb_userbit <= 1'b0;
    end else if (stb_cnt_inc >= delay_z_value) begin
      // Period boundary, one cycle pulse
      stb_cnt             <= '0;
      tx_auto_stb_userbit <= tx_stb_userbit;
    end else begin
      stb_cnt             <= stb_cnt_inc;
      tx_auto_stb_userbit <= 1'b0;
    end
  end

  // Marker passes only while TX is online
  assign tx_auto_mrk_userbit = tx_online ? tx_mrk_userbit : '0;

endmodule

//--- rtl/lpif_stream_pack.sv
//////////////////////////////
// Purely combinational field map
//////////////////////////////

`include "lpif_defs.svh"

module lpif_stream_pack (
  // Upstream stream
  input  lpif_stream_pkg::stream_state_t ustrm_state,
  input  lpif_stream_pkg::protid_t       ustrm_protid,
  input  logic [`LPIF_DATA_W-1:0]        ustrm_data,
  input  logic                           ustrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]         ustrm_crc,
  input  logic                           ustrm_crc_valid,
  input  logic                           ustrm_valid,

  // Link words
  output lpif_stream_pkg::link_word_t    tx_link_word,
  input  lpif_stream_pkg::link_word_t    rx_link_word,

  // Downstream stream
  output lpif_stream_pkg::stream_state_t dstrm_state,
  output lpif_stream_pkg::protid_t       dstrm_protid,
  output logic [`LPIF_DATA_W-1:0]        dstrm_data,
  output logic                           dstrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]         dstrm_crc,
  output logic                           dstrm_crc_valid,
  output logic                           dstrm_valid
);

  //////////////////////////////
  // Pack

  // Every link bit belongs to exactly one field
  always_comb begin
    tx_link_word                                        = '0;
    tx_link_word[`LPIF_VALID_LSB]                       = ustrm_valid;
    tx_link_word[`LPIF_CRCV_LSB]                        = ustrm_crc_valid;
    tx_link_word[`LPIF_CRC_LSB +: `LPIF_CRC_W]          = ustrm_crc;
    tx_link_word[`LPIF_DVALID_LSB]                      = ustrm_dvalid;
    tx_link_word[`LPIF_DATA_LSB +: `LPIF_DATA_W]        = ustrm_data;
    tx_link_word[`LPIF_PROTID_LSB +: `LPIF_PROTID_W]    = ustrm_protid;
    tx_link_word[`LPIF_STATE_LSB +: `LPIF_STATE_W]      = ustrm_state;
  end

  //////////////////////////////
  // Unpack

  // Same offsets on the way back
  assign dstrm_valid     = rx_link_word[`LPIF_VALID_LSB];
  assign dstrm_crc_valid = rx_link_word[`LPIF_CRCV_LSB];
  assign dstrm_crc       = rx_link_word[`LPIF_CRC_LSB +: `LPIF_CRC_W];
  assign dstrm_dvalid    = rx_link_word[`LPIF_DVALID_LSB];
  assign dstrm_data      = rx_link_word[`LPIF_DATA_LSB +: `LPIF_DATA_W];
  assign dstrm_protid    = rx_link_word[`LPIF_PROTID_LSB +: `LPIF_PROTID_W];
  assign dstrm_state     = rx_link_word[`LPIF_STATE_LSB +: `LPIF_STATE_W];

endmodule

//--- rtl/lpif_phy_concat.sv
//////////////////////////////
// One cycle each way, no flow control
// Channel bits 141 to 157 are sent as zero and ignored on receive
//////////////////////////////

`include "lpif_defs.svh"

module lpif_phy_concat (
  input  logic                        clk_wr,
  input  logic                        reset,

  // Link side
  input  lpif_stream_pkg::link_word_t tx_link_word,
  output lpif_stream_pkg::link_word_t rx_link_word,

  // Online levels, already delayed
  input  logic                        tx_online,
  input  logic                        rx_online,

  // Sync bits for the TX words
  input  logic                        tx_stb_userbit,
  input  lpif_phy_pkg::marker_t       tx_mrk_userbit,

  // PHY channels
  output lpif_phy_pkg::phy_word_t     tx_phy0,
  output lpif_phy_pkg::phy_word_t     tx_phy1,
  input  lpif_phy_pkg::phy_word_t     rx_phy0,
  input  lpif_phy_pkg::phy_word_t     rx_phy1
);

  logic [`LPIF_PHY0_SLICE-1:0] tx0_slice;
  logic [`LPIF_PHY0_SLICE-1:0] tx1_slice;
  lpif_phy_pkg::phy_word_t     tx0_next;
  lpif_phy_pkg::phy_word_t     tx1_next;
  lpif_stream_pkg::link_word_t rx_next;

  // Slice in the low bits, strobe and marker on top
  function automatic lpif_phy_pkg::phy_word_t build_word(
    input logic [`LPIF_PHY0_SLICE-1:0] slice,
    input logic                        stb,
    input logic                        mrk
  );
    lpif_phy_pkg::phy_word_t word;
    word                         = '0;
    word[`LPIF_PHY0_SLICE-1:0]   = slice;
    word[`LPIF_STB_BIT]          = stb;
    word[`LPIF_MRK_BIT]          = mrk;
    return word;
  endfunction

  //////////////////////////////
  // TX split

  assign tx0_slice = tx_link_word[0 +: `LPIF_PHY0_SLICE];
  // Channel 1 slice is one bit shorter
  assign tx1_slice = {1'b0, tx_link_word[`LPIF_PHY0_SLICE +: `LPIF_PHY1_SLICE]};

  assign tx0_next = build_word(tx0_slice, tx_stb_userbit, tx_mrk_userbit[0]);
  assign tx1_next = build_word(tx1_slice, tx_stb_userbit, tx_mrk_userbit[1]);

  // Both channels idle at zero until online
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= tx0_next;
      tx_phy1 <= tx1_next;
    end
  end

  //////////////////////////////
  // RX merge

  // Strobe and marker are dropped here
  assign rx_next = {rx_phy1[0 +: `LPIF_PHY1_SLICE], rx_phy0[0 +: `LPIF_PHY0_SLICE]};

  always_ff @(posedge clk_wr) begin
    if (reset || !rx_online) begin
      rx_link_word <= '0;
    end else begin
      rx_link_word <= rx_next;
    end
  end

endmodule

//--- rtl/lpif_txrx_top.sv
//////////////////////////////
// Single clock slave, no credit FIFO
//////////////////////////////

`include "lpif_defs.svh"

module lpif_txrx_top (
  input  logic                           clk_wr,
  input  logic                           reset,

  // Control
  input  logic                           tx_online,
  input  logic                           rx_online,

  // PHY channels
  output lpif_phy_pkg::phy_word_t        tx_phy0,
  input  lpif_phy_pkg::phy_word_t        rx_phy0,
  output lpif_phy_pkg::phy_word_t        tx_phy1,
  input  lpif_phy_pkg::phy_word_t        rx_phy1,

  // Downstream stream
  output lpif_stream_pkg::stream_state_t dstrm_state,
  output lpif_stream_pkg::protid_t       dstrm_protid,
  output logic [`LPIF_DATA_W-1:0]        dstrm_data,
  output logic                           dstrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]         dstrm_crc,
  output logic                           dstrm_crc_valid,
  output logic                           dstrm_valid,

  // Upstream stream
  input  lpif_stream_pkg::stream_state_t ustrm_state,
  input  lpif_stream_pkg::protid_t       ustrm_protid,
  input  logic [`LPIF_DATA_W-1:0]        ustrm_data,
  input  logic                           ustrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]         ustrm_crc,
  input  logic                           ustrm_crc_valid,
  input  logic                           ustrm_valid,

  // Sync bits and delays
  input  lpif_phy_pkg::marker_t          tx_mrk_userbit,
  input  logic                           tx_stb_userbit,
  input  logic [`LPIF_CNT_W-1:0]         delay_x_value,
  input  logic [`LPIF_CNT_W-1:0]         delay_y_value,
  input  logic [`LPIF_CNT_W-1:0]         delay_z_value
);

  //////////////////////////////
  // Internal wires

  lpif_stream_pkg::link_word_t tx_link_word;
  lpif_stream_pkg::link_word_t rx_link_word;
  lpif_phy_pkg::marker_t       tx_auto_mrk_userbit;
  logic                        tx_auto_stb_userbit;
  logic                        tx_online_delay;
  logic                        rx_online_delay;

  //////////////////////////////
  // Online delays, strobe and marker

  // Port names all match the wires above
  ll_auto_sync i_auto_sync (.*);

  //////////////////////////////
  // Stream field map

  lpif_stream_pack i_stream_pack (.*);

  //////////////////////////////
  // PHY split and merge

  // Concat sees only the delayed online levels
  lpif_phy_concat i_phy_concat (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .tx_link_word   (tx_link_word),
    .rx_link_word   (rx_link_word),
    .tx_online      (tx_online_delay),
    .rx_online      (rx_online_delay),
    .tx_stb_userbit (tx_auto_stb_userbit),
    .tx_mrk_userbit (tx_auto_mrk_userbit),
    .tx_phy0        (tx_phy0),
    .tx_phy1        (tx_phy1),
    .rx_phy0        (rx_phy0),
    .rx_phy1        (rx_phy1)
  );

endmodule

//--- testbench/lpif_txrx_assert.sv
//////////////////////////////
// Bound into lpif_txrx_top, sampled on clk_wr outside reset
//////////////////////////////

`include "lpif_defs.svh"

module lpif_txrx_assert (
  input logic                    clk_wr,
  input logic                    reset,
  input lpif_phy_pkg::phy_word_t tx_phy0,
  input lpif_phy_pkg::phy_word_t tx_phy1,
  input logic [`LPIF_CNT_W-1:0]  delay_z_value,
  input logic                    dstrm_valid,
  input logic                    tx_online_delay,
  input logic                    rx_online_delay
);

  // TX words are cleared one edge after the online level is seen low
  tx_zero_offline: assert property (@(posedge clk_wr) disable iff (reset)
    !tx_online_delay |=> (tx_phy0 == '0 && tx_phy1 == '0))
    else $error("TX channel word nonzero while TX is offline");

  // Single cycle strobe unless the period is 1
  stb_single: assert property (@(posedge clk_wr) disable iff (reset)
    (delay_z_value > 1 && tx_phy0[`LPIF_STB_BIT]) |=> !tx_phy0[`LPIF_STB_BIT])
    else $error("Strobe held high for two cycles");

  // RX word is cleared while offline
  rx_valid_offline: assert property (@(posedge clk_wr) disable iff (reset)
    !rx_online_delay |=> !dstrm_valid)
    else $error("dstrm_valid high while RX is offline");

endmodule

bind lpif_txrx_top lpif_txrx_assert i_assert (
  .clk_wr          (clk_wr),
  .reset           (reset),
  .tx_phy0         (tx_phy0),
  .tx_phy1         (tx_phy1),
  .delay_z_value   (delay_z_value),
  .dstrm_valid     (dstrm_valid),
  .tx_online_delay (tx_online_delay),
  .rx_online_delay (rx_online_delay)
);

//--- testbench/tb_lpif_txrx.sv
//////////////////////////////
// Reads testbench/lpif_trace.txt relative to the project root
// Loopback mode routes tx_phy0/1 straight into rx_phy0/1
//////////////////////////////

`include "lpif_defs.svh"

module tb_lpif_txrx;

  localparam int LW = `LPIF_LINK_W;

  logic clk_wr, reset, tx_online, rx_online, tx_stb_userbit, loopback;
  logic [`LPIF_CNT_W-1:0] delay_x_value, delay_y_value, delay_z_value;
  lpif_phy_pkg::marker_t tx_mrk_userbit;
  lpif_phy_pkg::phy_word_t tx_phy0, tx_phy1, rx_phy0, rx_phy1, rx_drv0, rx_drv1;
  lpif_stream_pkg::stream_state_t ustrm_state, dstrm_state;
  lpif_stream_pkg::protid_t ustrm_protid, dstrm_protid;
  logic [`LPIF_DATA_W-1:0] ustrm_data, dstrm_data;
  logic [`LPIF_CRC_W-1:0] ustrm_crc, dstrm_crc;
  logic ustrm_dvalid, ustrm_crc_valid, ustrm_valid;
  logic dstrm_dvalid, dstrm_crc_valid, dstrm_valid;
  logic [31:0] lfsr;
  int errors, checks, tests;

  // RX channels come from the trace or from the TX side
  assign rx_phy0 = loopback ? tx_phy0 : rx_drv0;
  assign rx_phy1 = loopback ? tx_phy1 : rx_drv1;

  lpif_txrx_top i_dut (.*);

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  //////////////////////////////
  // Helpers

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(output logic [LW-1:0] v);
    v = '0;
    for (int i = 0; i < LW; i++) begin
      v = {v[LW-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic compare_value(input string name, input logic [LW-1:0] exp_v,
                               input logic [LW-1:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    end
  endtask

  // Advance one edge and sample at the falling edge
  task automatic step();
    @(posedge clk_wr);
    @(negedge clk_wr);
  endtask

  task automatic end_test(input string name, input int start);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - start);
  endtask

  // Link word field map with valid at bit 0 and state on top
  task automatic drive_upstream(input logic [LW-1:0] w);
    ustrm_valid     <= w[0];
    ustrm_crc_valid <= w[1];
    ustrm_crc       <= w[17:2];
    ustrm_dvalid    <= w[18];
    ustrm_data      <= w[274:19];
    ustrm_protid    <= w[276:275];
    ustrm_state     <= w[280:277];
  endtask

  task automatic check_downstream(input logic [LW-1:0] w);
    compare_value("dstrm_valid", w[0], dstrm_valid);
    compare_value("dstrm_crc_valid", w[1], dstrm_crc_valid);
    compare_value("dstrm_crc", w[17:2], dstrm_crc);
    compare_value("dstrm_dvalid", w[18], dstrm_dvalid);
    compare_value("dstrm_data", w[274:19], dstrm_data);
    compare_value("dstrm_protid", w[276:275], dstrm_protid);
    compare_value("dstrm_state", w[280:277], dstrm_state);
  endtask

  // Drive both channels with all ones in the bits the RX merge must drop
  task automatic drive_rx(input logic [LW-1:0] w);
    rx_drv0 <= {19'h7ffff, w[140:0]};
    rx_drv1 <= {20'hfffff, w[280:141]};
  endtask

  task automatic wait_quiet(input string what);
    int n;
    n = 0;
    do begin
      step();
      n++;
    end while (n < 16 && ({tx_phy0, tx_phy1} != '0 || dstrm_data != '0 || dstrm_valid));
    if ({tx_phy0, tx_phy1} != '0 || dstrm_data != '0 || dstrm_valid) begin
      errors++;
      $display("Timeout at %0t: %s did not return to zero", $time, what);
    end
  endtask

  //////////////////////////////
  // Test steps

  task automatic run_tx_test(input int dly, input int period, input logic [1:0] mrk,
                             input int exp_first, input int n_stb);
    logic [LW-1:0] w;
    int n;
    draw_bits(w);
    @(posedge clk_wr);
    delay_y_value  <= dly[15:0];
    delay_z_value  <= period[15:0];
    tx_mrk_userbit <= mrk;
    tx_stb_userbit <= 1'b1;
    tx_online      <= 1'b1;
    drive_upstream(w);
    // Edges until the first word leaves
    n = 0;
    do begin
      step();
      n++;
    end while (n < 64 && {tx_phy0, tx_phy1} == '0);
    if ({tx_phy0, tx_phy1} == '0) begin
      errors++;
      $display("Timeout at %0t: TX words never left zero", $time);
    end else begin
      compare_value("tx first word cycle", exp_first, n);
      compare_value("tx_phy0 slice", w[140:0], tx_phy0[140:0]);
      compare_value("tx_phy1 slice", w[280:141], tx_phy1[139:0]);
      compare_value("tx_phy0 gap", '0, tx_phy0[157:141]);
      compare_value("tx_phy1 gap", '0, tx_phy1[157:140]);
      compare_value("tx_phy0 marker", mrk[0], tx_phy0[`LPIF_MRK_BIT]);
      compare_value("tx_phy1 marker", mrk[1], tx_phy1[`LPIF_MRK_BIT]);
    end
    // First strobe and then one every period
    n = 0;
    do begin
      step();
      n++;
    end while (n < 2 * period + 4 && !tx_phy0[`LPIF_STB_BIT]);
    if (!tx_phy0[`LPIF_STB_BIT]) begin
      errors++;
      $display("Timeout at %0t: no strobe seen on tx_phy0", $time);
    end else begin
      compare_value("tx_phy1 strobe", 1, tx_phy1[`LPIF_STB_BIT]);
      for (int k = 1; k < n_stb; k++) begin
        for (int c = 1; c <= period; c++) begin
          step();
          compare_value("tx_phy0 strobe", c == period, tx_phy0[`LPIF_STB_BIT]);
          compare_value("tx_phy1 strobe", c == period, tx_phy1[`LPIF_STB_BIT]);
        end
      end
    end
    @(posedge clk_wr);
    tx_online <= 1'b0;
    wait_quiet("TX words");
  endtask

  task automatic run_rx_test(input int dly, input logic [LW-1:0] w, input int exp_first);
    logic [LW-1:0] w2;
    int n;
    draw_bits(w2);
    @(posedge clk_wr);
    delay_x_value <= dly[15:0];
    rx_online     <= 1'b1;
    drive_rx(w);
    n = 0;
    do begin
      step();
      n++;
    end while (n < 64 && dstrm_data == '0 && !dstrm_valid);
    if (dstrm_data == '0 && !dstrm_valid) begin
      errors++;
      $display("Timeout at %0t: downstream outputs never left zero", $time);
    end else begin
      compare_value("rx first word cycle", exp_first, n);
      check_downstream(w);
      // New RX word shows one edge after it is sampled
      @(posedge clk_wr);
      drive_rx(w2);
      @(negedge clk_wr);
      check_downstream(w);
      step();
      check_downstream(w2);
    end
    @(posedge clk_wr);
    rx_online <= 1'b0;
    wait_quiet("downstream outputs");
  endtask

  task automatic run_loop_test(input int dx, input int dy, input int count);
    logic [LW-1:0] w;
    logic [LW-1:0] exp_q[$];
    int n;
    @(posedge clk_wr);
    loopback      <= 1'b1;
    delay_x_value <= dx[15:0];
    delay_y_value <= dy[15:0];
    tx_online     <= 1'b1;
    rx_online     <= 1'b1;
    n = 0;
    do begin
      step();
      n++;
    end while (n < 64 && !(i_dut.tx_online_delay && i_dut.rx_online_delay));
    if (!(i_dut.tx_online_delay && i_dut.rx_online_delay)) begin
      errors++;
      $display("Timeout at %0t: link did not come online for loopback", $time);
    end
    // Two words in flight with each due two edges after it is driven
    for (int i = 0; i < count + 2; i++) begin
      @(posedge clk_wr);
      if (i < count) begin
        draw_bits(w);
        drive_upstream(w);
        exp_q.push_back(w);
      end
      @(negedge clk_wr);
      if (i >= 2) check_downstream(exp_q.pop_front());
    end
    @(posedge clk_wr);
    loopback  <= 1'b0;
    tx_online <= 1'b0;
    rx_online <= 1'b0;
    wait_quiet("loopback path");
  endtask

  //////////////////////////////
  // Main sequence

  initial begin
    int fd;
    int code;
    int start;
    int p[8];
    string op;
    string line;
    logic [LW-1:0] data;
    reset = 1'b1;
    {tx_online, rx_online, tx_stb_userbit, loopback} = '0;
    {delay_x_value, delay_y_value, delay_z_value, tx_mrk_userbit} = '0;
    {rx_drv0, rx_drv1} = '0;
    {ustrm_state, ustrm_protid, ustrm_data, ustrm_crc} = '0;
    {ustrm_dvalid, ustrm_crc_valid, ustrm_valid} = '0;
    lfsr = 32'd38;
    errors = 0;
    checks = 0;
    tests = 0;
    fd = $fopen("testbench/lpif_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the trace file");
    end
    repeat (10) @(posedge clk_wr);
    reset <= 1'b0;
    start = errors;
    step();
    check_downstream('0);
    compare_value("tx_phy0", '0, tx_phy0);
    compare_value("tx_phy1", '0, tx_phy1);
    end_test("reset", start);
    while (fd != 0 && !$feof(fd)) begin
      code = $fscanf(fd, "%s", op);
      if (code == 1) begin
        start = errors;
        case (op)
          "#": code = $fgets(line, fd);
          "T": begin
            code = $fscanf(fd, "%d %d %h %d %d", p[0], p[1], p[2], p[3], p[4]);
            run_tx_test(p[0], p[1], p[2][1:0], p[3], p[4]);
            end_test("tx online and strobe", start);
          end
          "R": begin
            code = $fscanf(fd, "%d %h %h %h %h %h %h %d",
                           p[0], p[1], p[2], p[3], p[4], p[5], p[6], p[7]);
            draw_bits(data);
            run_rx_test(p[0], {p[1][3:0], p[2][1:0], data[255:0], p[4][0], p[3][15:0],
                               p[5][0], p[6][0]}, p[7]);
            end_test("rx online and unpack", start);
          end
          "L": begin
            code = $fscanf(fd, "%d %d %d", p[0], p[1], p[2]);
            run_loop_test(p[0], p[1], p[2]);
            end_test("loopback", start);
          end
          default: begin
            errors++;
            $display("Unknown trace step %s", op);
          end
        endcase
      end
    end
    if (fd != 0) $fclose(fd);
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
rtl/lpif_stream_pkg.sv
rtl/lpif_phy_pkg.sv
rtl/ll_auto_sync.sv
rtl/lpif_stream_pack.sv
rtl/lpif_phy_concat.sv
rtl/lpif_txrx_top.sv
testbench/lpif_txrx_assert.sv
testbench/tb_lpif_txrx.sv

//--- Makefile
# Verilator flow, run from the project root
TOP = tb_lpif_txrx

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	  if [ $$status -ne 0 ] || grep -q "TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- testbench/lpif_trace.txt
# T delay_y delay_z marker(hex) first_word_cycle strobe_count
# R delay_x state protid crc dvalid crc_valid valid (hex) first_word_cycle
# L delay_x delay_y word_count
# TX online delay, marker and strobe period
T 3 4 2 5 4
T 0 1 1 2 5
T 5 3 3 7 4
# RX online and unpack, junk in strobe and marker bits
R 2 5 1 beef 1 0 1 4
R 0 a 3 1234 0 1 1 2
R 6 f 2 0001 1 1 0 8
R 1 0 0 0000 0 0 0 3
# Loopback with random words
L 1 2 40
L 0 0 25
